//--- sim.f
design/rmt_pkg.sv
design/sync_fifo.sv
design/pkt_classifier.sv
design/rmt_ctrl.sv
design/match_stage.sv
design/deparser.sv
design/rmt_top.sv
test/tb_rmt.sv

//--- test/tb_rmt.sv
`timescale 1ns/10ps

module tb_rmt;

	// run length in packets and commands, sets the timeout
	localparam int n_pkts = 64;
	localparam int n_cmds = 23;
	// about a dozen cycles per packet at worst, four times over
	localparam int cycle_limit = 4 * 12 * (n_pkts + n_cmds);

	logic clk;
	logic aresetn;
	rmt_pkg::axis_beat_t s_beat;
	logic s_valid;
	logic s_ready;
	rmt_pkg::axis_beat_t m_beat;
	logic m_valid;
	logic m_ready;
	logic [31:0] ctrl_token;

	int seed;
	int ready_seed;
	int cycles;
	logic bp_on;
	logic tok_check;
	logic [31:0] exp_token;
	// table model, written from the commands sent
	rmt_pkg::act_entry_t mdl [rmt_pkg::num_stages][rmt_pkg::tbl_depth];
	// expected output beats, head mirrored into plain signals
	rmt_pkg::axis_beat_t exp_q [$];
	rmt_pkg::axis_beat_t exp_head;
	logic exp_have;

	rmt_top u_dut (.clk(clk), .aresetn(aresetn),
		.s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
		.m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready),
		.ctrl_token(ctrl_token));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic void refresh_head();
		exp_have = (exp_q.size() != 0);
		if (exp_have)
			exp_head = exp_q[0];
	endfunction

	function automatic void push_expect(input rmt_pkg::axis_beat_t b);
		exp_q.push_back(b);
		refresh_head();
	endfunction

	function automatic int pick_len(input int max_len);
		return 1 + ($unsigned($random(seed)) % max_len);
	endfunction

	// mostly add and set, some nop
	function automatic logic [7:0] pick_op();
		logic [31:0] r;
		r = $random(seed);
		case (r[1:0])
			2'd1: return 8'd2;
			2'd2: return 8'd0;
			default: return 8'd1;
		endcase
	endfunction

	// header after all three stages
	function automatic rmt_pkg::phv_t expect_phv(input rmt_pkg::phv_t p);
		rmt_pkg::phv_t r;
		rmt_pkg::act_entry_t e;
		r = p;
		for (int i = 0; i < rmt_pkg::num_stages; i++) begin
			e = mdl[i][p.tag[1:0]];
			if (e.op == rmt_pkg::op_add)
				r.fld[i] = p.fld[i] + e.operand;
			else if (e.op == rmt_pkg::op_set)
				r.fld[i] = e.operand;
		end
		return r;
	endfunction

	// called 2 ns after an edge, returns 2 ns after the accepting edge
	task automatic send_beat(input rmt_pkg::axis_beat_t b);
		s_beat = b;
		s_valid = 1'b1;
		do
			@(posedge clk);
		while (!s_ready);
		#2;
		s_valid = 1'b0;
	endtask

	task automatic send_data(input logic [7:0] tag, input int len);
		rmt_pkg::phv_t p;
		rmt_pkg::axis_beat_t b;
		rmt_pkg::axis_beat_t beats [$];
		p.kind = rmt_pkg::kind_data;
		p.tag = tag;
		for (int i = 0; i < rmt_pkg::num_stages; i++)
			p.fld[i] = 16'($random(seed));
		b.data = p;
		b.last = (len == 1);
		beats.push_back(b);
		for (int i = 1; i < len; i++) begin
			b.data = {$random(seed), $random(seed)};
			b.last = (i == len - 1);
			beats.push_back(b);
		end
		// first beat leaves with the rewritten header
		b = beats[0];
		b.data = expect_phv(p);
		push_expect(b);
		for (int i = 1; i < len; i++)
			push_expect(beats[i]);
		foreach (beats[i])
			send_beat(beats[i]);
	endtask

	// unknown kind, never reaches the output
	task automatic send_drop(input int len);
		rmt_pkg::axis_beat_t b;
		b.data = {$random(seed), $random(seed)};
		while (b.data[63:56] == rmt_pkg::kind_data || b.data[63:56] == rmt_pkg::kind_ctrl)
			b.data[63:56] = 8'($random(seed));
		for (int i = 0; i < len; i++) begin
			b.last = (i == len - 1);
			send_beat(b);
			b.data = {$random(seed), $random(seed)};
		end
	endtask

	task automatic send_ctrl(input logic [7:0] stage, input logic [7:0] slot,
		input logic [7:0] op, input logic [15:0] operand);
		rmt_pkg::ctrl_cmd_t c;
		rmt_pkg::axis_beat_t b;
		int len;
		c.kind = rmt_pkg::kind_ctrl;
		c.stage = stage;
		c.slot = slot;
		c.op = op;
		c.operand = operand;
		c.reserved = 16'($random(seed));
		len = pick_len(2);
		// only well formed commands reach the tables
		if (stage < rmt_pkg::num_stages && op[1:0] != 2'd3) begin
			mdl[stage][slot[1:0]].op = rmt_pkg::act_op_e'(op[1:0]);
			mdl[stage][slot[1:0]].operand = operand;
			exp_token = exp_token + 1;
		end
		b.data = c;
		b.last = (len == 1);
		send_beat(b);
		if (len == 2) begin
			b.data = {$random(seed), $random(seed)};
			b.last = 1'b1;
			send_beat(b);
		end
	endtask

	task automatic send_mixed();
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] < 3'd5)
			send_data(r[15:8], pick_len(4));
		else
			send_drop(pick_len(4));
	endtask

	// queue empty, then a few idle cycles for tables and token
	task automatic wait_drain();
		do begin
			@(posedge clk);
			#1;
		end while (exp_q.size() != 0);
		repeat (4) @(posedge clk);
		#2;
	endtask

	task automatic check_token();
		tok_check = 1'b1;
		@(posedge clk);
		#2;
		tok_check = 1'b0;
	endtask

	// retire the head on each output transfer
	always @(posedge clk) begin
		if (aresetn && m_valid && m_ready && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
			refresh_head();
		end
	end

	// sink stalls at random while bp_on is set
	initial begin
		m_ready = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			m_ready = bp_on ? 1'($random(ready_seed)) : 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, output never drained", cycles);
			stop_run();
		end
	end

	a_reset_state: assert property (@(posedge clk)
		$rose(aresetn) |-> !m_valid && ctrl_token == 0 && s_ready)
		else begin
			$display("outputs were not at their reset values at %0t", $time);
			stop_run();
		end

	a_beat_expected: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && m_ready |-> exp_have)
		else begin
			$display("output beat at %0t with no packet left to expect", $time);
			stop_run();
		end

	a_beat_data: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && m_ready && exp_have |-> m_beat.data == exp_head.data)
		else begin
			$display("[ERROR] %0t m_beat.data got %h expected %h", $time,
				$sampled(m_beat.data), $sampled(exp_head.data));
			stop_run();
		end

	a_beat_last: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && m_ready && exp_have |-> m_beat.last == exp_head.last)
		else begin
			$display("[ERROR] %0t m_beat.last got %b expected %b", $time,
				$sampled(m_beat.last), $sampled(exp_head.last));
			stop_run();
		end

	a_hold_out: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat))
		else begin
			$display("output beat changed at %0t while the sink was stalling", $time);
			stop_run();
		end

	a_token: assert property (@(posedge clk) disable iff (!aresetn)
		tok_check |-> ctrl_token == exp_token)
		else begin
			$display("[ERROR] %0t ctrl_token got %0d expected %0d", $time,
				$sampled(ctrl_token), $sampled(exp_token));
			stop_run();
		end

	initial begin
		seed = 32'h6830_6697;
		// own stream so stalls do not shift the stimulus
		ready_seed = 32'h6830_6697;
		cycles = 0;
		aresetn = 1'b0;
		s_valid = 1'b0;
		s_beat = '0;
		bp_on = 1'b0;
		tok_check = 1'b0;
		exp_token = '0;
		exp_have = 1'b0;
		exp_head = '0;
		for (int s = 0; s < rmt_pkg::num_stages; s++)
			for (int k = 0; k < rmt_pkg::tbl_depth; k++)
				mdl[s][k] = '{op: rmt_pkg::op_nop, operand: 16'h0};
		repeat (4) @(posedge clk);
		#2;
		aresetn = 1'b1;
		@(posedge clk);
		#2;
		// tables still all nop
		repeat (4) send_data(8'($random(seed)), pick_len(4));
		wait_drain();
		check_token();
		// program every slot of every stage
		for (int s = 0; s < rmt_pkg::num_stages; s++)
			for (int k = 0; k < rmt_pkg::tbl_depth; k++)
				send_ctrl(8'(s), 8'(k), pick_op(), 16'($random(seed)));
		wait_drain();
		check_token();
		repeat (20) send_mixed();
		wait_drain();
		// bad stage or undefined op
		send_ctrl(8'd3, 8'd0, 8'd1, 16'($random(seed)));
		send_ctrl(8'hFF, 8'd1, 8'd2, 16'($random(seed)));
		send_ctrl(8'd200, 8'd2, 8'd1, 16'($random(seed)));
		send_ctrl(8'd0, 8'd2, 8'h03, 16'($random(seed)));
		send_ctrl(8'd1, 8'd3, 8'hFF, 16'($random(seed)));
		send_ctrl(8'd2, 8'd1, 8'h07, 16'($random(seed)));
		// upper op bits ignored, decodes as add
		send_ctrl(8'd1, 8'd2, 8'h41, 16'($random(seed)));
		wait_drain();
		check_token();
		repeat (10) send_data(8'($random(seed)), pick_len(4));
		wait_drain();
		// random stalls on the output
		bp_on = 1'b1;
		repeat (4) send_ctrl(8'($unsigned($random(seed)) % 3), 8'($random(seed)),
			pick_op(), 16'($random(seed)));
		wait_drain();
		repeat (30) send_mixed();
		wait_drain();
		bp_on = 1'b0;
		check_token();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- design/rmt_top.sv
`timescale 1ns/10ps

module rmt_top (
	input logic clk,
	input logic aresetn,
	input rmt_pkg::axis_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	output rmt_pkg::axis_beat_t m_beat,
	output logic m_valid,
	input logic m_ready,
	output logic [31:0] ctrl_token
);

	// classifier to packet FIFO
	rmt_pkg::axis_beat_t cls_beat;
	logic cls_wr;
	logic pkt_nearly_full;
	rmt_pkg::axis_beat_t pkt_beat;
	logic pkt_empty;
	logic pkt_rd;

	// header path through the stages
	rmt_pkg::phv_t phv_s0_in;
	logic phv_s0_in_valid;
	rmt_pkg::phv_t phv_s0_out;
	logic phv_s0_out_valid;
	rmt_pkg::phv_t phv_s1_out;
	logic phv_s1_out_valid;
	rmt_pkg::phv_t phv_s2_out;
	logic phv_s2_out_valid;
	rmt_pkg::phv_t phv_fifo_out;
	logic phv_nearly_full;
	logic phv_empty;
	logic phv_rd;

	// control path
	rmt_pkg::ctrl_cmd_t cmd;
	logic cmd_valid;
	rmt_pkg::tbl_wr_t tbl_wr;
	logic [rmt_pkg::num_stages-1:0] tbl_wr_en;

	pkt_classifier u_classifier (.clk(clk), .aresetn(aresetn),
		.s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
		.pkt_nearly_full(pkt_nearly_full), .phv_nearly_full(phv_nearly_full),
		.fifo_beat(cls_beat), .fifo_wr(cls_wr),
		.phv(phv_s0_in), .phv_valid(phv_s0_in_valid),
		.cmd(cmd), .cmd_valid(cmd_valid));

	sync_fifo #(.WIDTH($bits(rmt_pkg::axis_beat_t)), .DEPTH(rmt_pkg::fifo_depth)) u_pkt_fifo (
		.clk(clk), .aresetn(aresetn), .wr_en(cls_wr), .wr_data(cls_beat),
		.rd_en(pkt_rd), .rd_data(pkt_beat), .empty(pkt_empty),
		.nearly_full(pkt_nearly_full));

	rmt_ctrl u_ctrl (.clk(clk), .aresetn(aresetn), .cmd(cmd), .cmd_valid(cmd_valid),
		.tbl_wr(tbl_wr), .tbl_wr_en(tbl_wr_en), .ctrl_token(ctrl_token));

	match_stage #(.STAGE_ID(0)) u_stage0 (.clk(clk), .aresetn(aresetn),
		.tbl_wr(tbl_wr), .tbl_wr_en(tbl_wr_en[0]),
		.phv_in(phv_s0_in), .phv_in_valid(phv_s0_in_valid),
		.phv_out(phv_s0_out), .phv_out_valid(phv_s0_out_valid));

	match_stage #(.STAGE_ID(1)) u_stage1 (.clk(clk), .aresetn(aresetn),
		.tbl_wr(tbl_wr), .tbl_wr_en(tbl_wr_en[1]),
		.phv_in(phv_s0_out), .phv_in_valid(phv_s0_out_valid),
		.phv_out(phv_s1_out), .phv_out_valid(phv_s1_out_valid));

	match_stage #(.STAGE_ID(2)) u_stage2 (.clk(clk), .aresetn(aresetn),
		.tbl_wr(tbl_wr), .tbl_wr_en(tbl_wr_en[2]),
		.phv_in(phv_s1_out), .phv_in_valid(phv_s1_out_valid),
		.phv_out(phv_s2_out), .phv_out_valid(phv_s2_out_valid));

	sync_fifo #(.WIDTH($bits(rmt_pkg::phv_t)), .DEPTH(rmt_pkg::fifo_depth)) u_phv_fifo (
		.clk(clk), .aresetn(aresetn), .wr_en(phv_s2_out_valid), .wr_data(phv_s2_out),
		.rd_en(phv_rd), .rd_data(phv_fifo_out), .empty(phv_empty),
		.nearly_full(phv_nearly_full));

	deparser u_deparser (.clk(clk), .aresetn(aresetn),
		.pkt_beat(pkt_beat), .pkt_empty(pkt_empty), .pkt_rd(pkt_rd),
		.phv(phv_fifo_out), .phv_empty(phv_empty), .phv_rd(phv_rd),
		.m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready));

endmodule

//--- design/deparser.sv
`timescale 1ns/10ps

module deparser (
	input logic clk,
	input logic aresetn,
	input rmt_pkg::axis_beat_t pkt_beat,
	input logic pkt_empty,
	output logic pkt_rd,
	input rmt_pkg::phv_t phv,
	input logic phv_empty,
	output logic phv_rd,
	output rmt_pkg::axis_beat_t m_beat,
	output logic m_valid,
	input logic m_ready
);

	// set while waiting for the start of a packet
	logic first_beat;
	// output register can take a new beat this cycle
	logic out_free;
	// next beat is present in the FIFOs
	logic src_avail;
	logic take;

	assign out_free = !m_valid || m_ready;

	// a packet starts only once its header vector has come out of the stages
	assign src_avail = first_beat ? (!pkt_empty && !phv_empty) : !pkt_empty;
	assign take = out_free && src_avail;

	// pops happen as the beat moves into the output register
	assign pkt_rd = take;
	assign phv_rd = take && first_beat;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
			m_valid <= 1'b0;
		end else begin
			if (take) begin
				m_valid <= 1'b1;
				first_beat <= pkt_beat.last;
			end else if (m_ready) begin
				// beat went out, nothing behind it
				m_valid <= 1'b0;
			end
		end
	end

	// output payload only moves on take, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (take) begin
			// first beat carries the modified header
			m_beat.data <= first_beat ? phv : pkt_beat.data;
			m_beat.last <= pkt_beat.last;
		end
	end

	// stream rule on the output side
	a_hold_beat: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

//--- design/match_stage.sv
`timescale 1ns/10ps

module match_stage #(
	parameter int STAGE_ID = 0
) (
	input logic clk,
	input logic aresetn,
	input rmt_pkg::tbl_wr_t tbl_wr,
	input logic tbl_wr_en,
	input rmt_pkg::phv_t phv_in,
	input logic phv_in_valid,
	output rmt_pkg::phv_t phv_out,
	output logic phv_out_valid
);

	// action table, indexed straight from the tag
	rmt_pkg::act_entry_t tbl [rmt_pkg::tbl_depth];
	rmt_pkg::act_entry_t hit;
	logic [15:0] fld_cur;
	logic [15:0] fld_new;

	assign hit = tbl[phv_in.tag[$clog2(rmt_pkg::tbl_depth)-1:0]];
	assign fld_cur = phv_in.fld[STAGE_ID];

	// apply the selected action to this stage's field
	always_comb begin
		case (hit.op)
			rmt_pkg::op_add: fld_new = fld_cur + hit.operand;
			rmt_pkg::op_set: fld_new = hit.operand;
			default: fld_new = fld_cur;
		endcase
	end

	// table writes land at the next edge
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < rmt_pkg::tbl_depth; i++) begin
				tbl[i].op <= rmt_pkg::op_nop;
				tbl[i].operand <= '0;
			end
		end else if (tbl_wr_en) begin
			tbl[tbl_wr.slot] <= tbl_wr.entry;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	// rest of the vector passes through untouched
	always_ff @(posedge clk) begin
		phv_out <= phv_in;
		phv_out.fld[STAGE_ID] <= fld_new;
	end

endmodule

//--- design/rmt_ctrl.sv
`timescale 1ns/10ps

module rmt_ctrl (
	input logic clk,
	input logic aresetn,
	input rmt_pkg::ctrl_cmd_t cmd,
	input logic cmd_valid,
	output rmt_pkg::tbl_wr_t tbl_wr,
	output logic [rmt_pkg::num_stages-1:0] tbl_wr_en,
	output logic [31:0] ctrl_token
);

	rmt_pkg::act_op_e cmd_op;
	logic stage_ok;
	logic op_ok;
	logic apply;

	// only the low two opcode bits carry meaning
	assign cmd_op = rmt_pkg::act_op_e'(cmd.op[1:0]);
	assign stage_ok = (cmd.stage < rmt_pkg::num_stages);
	assign op_ok = (cmd_op == rmt_pkg::op_nop) || (cmd_op == rmt_pkg::op_add) ||
		(cmd_op == rmt_pkg::op_set);
	// malformed commands are silently dropped
	assign apply = cmd_valid && stage_ok && op_ok;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			tbl_wr_en <= '0;
			ctrl_token <= '0;
		end else begin
			tbl_wr_en <= '0;
			if (apply) begin
				// one-hot select of the target stage
				tbl_wr_en[cmd.stage[1:0]] <= 1'b1;
				ctrl_token <= ctrl_token + 1'b1;
			end
		end
	end

	// broadcast entry, only the selected stage latches it
	always_ff @(posedge clk) begin
		tbl_wr.slot <= cmd.slot[$bits(tbl_wr.slot)-1:0];
		tbl_wr.entry.op <= cmd_op;
		tbl_wr.entry.operand <= cmd.operand;
	end

endmodule

//--- design/pkt_classifier.sv
`timescale 1ns/10ps

module pkt_classifier (
	input logic clk,
	input logic aresetn,
	input rmt_pkg::axis_beat_t s_beat,
	input logic s_valid,
	output logic s_ready,
	input logic pkt_nearly_full,
	input logic phv_nearly_full,
	output rmt_pkg::axis_beat_t fifo_beat,
	output logic fifo_wr,
	output rmt_pkg::phv_t phv,
	output logic phv_valid,
	output rmt_pkg::ctrl_cmd_t cmd,
	output logic cmd_valid
);

	rmt_pkg::hdr_word_u hdr;
	logic accept;
	logic first_beat;
	// class of the packet in progress, set means data
	// control and unknown packets both fall through to discard
	logic cls_data;
	logic hdr_data;
	logic hdr_ctrl;
	logic beat_data;

	// same word, two decodes
	assign hdr = s_beat.data;
	assign hdr_data = (hdr.phv.kind == rmt_pkg::kind_data);
	assign hdr_ctrl = (hdr.cmd.kind == rmt_pkg::kind_ctrl);

	// stall input while either downstream FIFO runs short of room
	assign s_ready = !pkt_nearly_full && !phv_nearly_full;
	assign accept = s_valid && s_ready;

	// first beat decides for itself, later beats follow the class register
	assign beat_data = first_beat ? hdr_data : cls_data;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
			cls_data <= 1'b0;
			fifo_wr <= 1'b0;
			phv_valid <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			// single-cycle strobes by default
			fifo_wr <= accept && beat_data;
			phv_valid <= accept && first_beat && hdr_data;
			cmd_valid <= accept && first_beat && hdr_ctrl;
			if (accept) begin
				// next beat starts a new packet after last
				first_beat <= s_beat.last;
				if (first_beat)
					cls_data <= hdr_data;
			end
		end
	end

	// payload copies, qualified by the strobes above
	always_ff @(posedge clk) begin
		fifo_beat <= s_beat;
		phv <= hdr.phv;
		cmd <= hdr.cmd;
	end

	// a first beat is either data or control, never both
	a_kind_excl: assert property (@(posedge clk) disable iff (!aresetn)
		!(phv_valid && cmd_valid));

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic aresetn,
	input logic wr_en,
	input logic [WIDTH-1:0] wr_data,
	input logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty,
	output logic nearly_full
);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic full;

	assign empty = (count == 0);
	assign full = (count == DEPTH);
	// six spare entries cover what is still in flight upstream,
	// one beat in the classifier register plus the four-cycle header path
	assign nearly_full = (count >= DEPTH - 6);
	// first word falls through
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			// occupancy only moves on a lone read or a lone write
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	// storage itself
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	// upstream must honour nearly_full early enough
	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn) wr_en |-> !full);
	// consumer must check empty before popping
	a_no_underflow: assert property (@(posedge clk) disable iff (!aresetn) rd_en |-> !empty);

endmodule

//--- design/rmt_pkg.sv
package rmt_pkg;

	// stream and pipeline sizing
	localparam int data_w = 64;
	localparam int num_stages = 3;
	localparam int tbl_depth = 4;
	localparam int fifo_depth = 16;

	// kind codes, always the top byte of a first beat
	localparam logic [7:0] kind_data = 8'h11;
	localparam logic [7:0] kind_ctrl = 8'hF1;

	// one stream beat, no keep or user sideband
	typedef struct packed {
		logic [data_w-1:0] data;
		logic last;
	} axis_beat_t;

	// header vector, same width as one beat
	// fld[i] is the field owned by stage i
	typedef struct packed {
		logic [7:0] kind;
		logic [num_stages-1:0][15:0] fld;
		logic [7:0] tag;
	} phv_t;

	// action opcodes, encoding 2'd3 left undefined
	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_add = 2'd1,
		op_set = 2'd2
	} act_op_e;

	typedef struct packed {
		act_op_e op;
		logic [15:0] operand;
	} act_entry_t;

	// control packet first beat
	// op is a full byte on the wire, only op[1:0] is meaningful
	typedef struct packed {
		logic [7:0] kind;
		logic [7:0] stage;
		logic [7:0] slot;
		logic [7:0] op;
		logic [15:0] operand;
		logic [15:0] reserved;
	} ctrl_cmd_t;

	// first beat seen either as header vector or as command
	typedef union packed {
		phv_t phv;
		ctrl_cmd_t cmd;
	} hdr_word_u;

	// table write broadcast to every stage
	typedef struct packed {
		logic [$clog2(tbl_depth)-1:0] slot;
		act_entry_t entry;
	} tbl_wr_t;

endpackage
